// File: common/ofdm_tx_consts.svh
// Widths and register byte offsets of the OFDM transmit wrapper
// include in any file that sizes BRAM, stream or AXI-Lite signals
`ifndef OFDM_TX_CONSTS_SVH
`define OFDM_TX_CONSTS_SVH

`define OFDM_TX_BRAM_AW 10 // 1k words of frame memory
`define OFDM_TX_WORD_W  64

`define OFDM_TX_AXI_AW  7
`define OFDM_TX_AXI_DW  32

`define OFDM_TX_REG_CTRL       7'h00 // bit 0 soft reset
`define OFDM_TX_REG_PILOT_SEED 7'h04
`define OFDM_TX_REG_DATA_SEED  7'h08
`define OFDM_TX_REG_STATUS     7'h50 // read only

`endif

// File: common/ofdm_tx_reg_pkg.sv
// Register word layouts of the AXI4-Lite block
// imported by the register slave
package ofdm_tx_reg_pkg;

    // control word at offset 0x00
    typedef struct packed {
        logic [30:0] rsvd;
        logic        soft_reset; // holds the core in reset while set
    } ctrl_reg_t;

    // status word at offset 0x50
    typedef struct packed {
        logic [15:0] frame_count; // frames sent since arst_n, wraps
        logic [14:0] rsvd;
        logic        busy;
    } status_reg_t;

endpackage

// File: common/ofdm_tx_frame_pkg.sv
// Frame memory layout and control states of the transmit core
// imported by the control FSM
package ofdm_tx_frame_pkg;

    // word 0 of every frame
    typedef struct packed {
        logic [47:0] rsvd;
        logic [15:0] length_bytes; // 1 to 512
    } frame_hdr_t;

    // one BRAM word, header view for word 0 and payload view after it
    typedef union packed {
        frame_hdr_t  hdr;
        logic [63:0] payload; // bytes sent LSB first
    } bram_word_u;

    typedef enum logic [2:0] {
        st_idle,
        st_read_hdr, // word 0 on bram_din
        st_fetch,    // wait out BRAM latency
        st_stream,   // payload word offered to scrambler
        st_finish    // wait for last sample to leave
    } tx_state_e;

endpackage

// File: common/tx_stream_if.sv
// Valid/ready streams inside the transmit core
// words run from control to scrambler, bits from scrambler to mapper
`timescale 1ns/1ps
`include "ofdm_tx_consts.svh"

interface word_stream_if;
    logic                       valid;
    logic                       ready;
    logic [`OFDM_TX_WORD_W-1:0] data;
    logic [6:0]                 nbits; // valid bits in data, 1 to 64
    logic                       last;  // final word of the frame

    modport src (output valid, data, nbits, last, input ready);
    modport dst (input valid, data, nbits, last, output ready);
endinterface

interface bit_stream_if;
    logic valid;
    logic ready;
    logic data_bit; // scrambled payload bit
    logic last;     // final bit of the frame

    modport src (output valid, data_bit, last, input ready);
    modport dst (input valid, data_bit, last, output ready);
endinterface

// File: tx_core/tx_ctrl.sv
// Frame control FSM, reads the header word then streams payload words
// from BRAM to the scrambler and closes the start/done handshake
`timescale 1ns/1ps
`include "ofdm_tx_consts.svh"

module tx_ctrl import ofdm_tx_frame_pkg::*; (
    input  logic                         clk,
    input  logic                         core_rst_n,
    input  logic                         phy_tx_start,
    output logic                         phy_tx_started,
    output logic                         phy_tx_done,
    output logic                         busy,
    output logic [`OFDM_TX_BRAM_AW-1:0]  bram_addr,
    input  logic [`OFDM_TX_WORD_W-1:0]   bram_din,
    word_stream_if.src                   words,
    input  logic                         last_sample_taken
);
    tx_state_e   state_q;
    bram_word_u  din_u;
    logic [15:0] hdr_len;
    logic [16:0] len_round;
    logic [6:0]  words_left_q; // payload words still to send, up to 64
    logic [6:0]  last_nbits_q;

    assign din_u = bram_din;
    assign hdr_len = din_u.hdr.length_bytes;
    assign len_round = {1'b0, hdr_len} + 17'd7; // ceil to whole words

    assign busy = (state_q != st_idle);
    assign words.valid = (state_q == st_stream);
    assign words.data = din_u.payload; // stable while bram_addr holds
    assign words.last = (words_left_q == 7'd1);
    assign words.nbits = words.last ? last_nbits_q : 7'd64;

    always_ff @(posedge clk or negedge core_rst_n) begin
        if (!core_rst_n) begin
            state_q <= st_idle;
            bram_addr <= '0;
            words_left_q <= '0;
            last_nbits_q <= '0;
            phy_tx_started <= 1'b0;
            phy_tx_done <= 1'b0;
        end else begin
            phy_tx_started <= 1'b0;
            phy_tx_done <= 1'b0;
            case (state_q)
                st_idle: begin
                    if (phy_tx_start) begin // addr already 0, header arrives next cycle
                        phy_tx_started <= 1'b1;
                        state_q <= st_read_hdr;
                    end
                end
                st_read_hdr: begin
                    words_left_q <= len_round[9:3];
                    // partial tail word, 8 to 64 bits
                    last_nbits_q <= {(hdr_len[2:0] == 3'd0) ? 4'd8 : {1'b0, hdr_len[2:0]},
                                     3'b000};
                    bram_addr <= bram_addr + 1'b1;
                    state_q <= st_fetch;
                end
                st_fetch: state_q <= st_stream; // one cycle BRAM latency
                st_stream: begin
                    if (words.ready) begin
                        if (words.last) begin
                            state_q <= st_finish;
                        end else begin
                            bram_addr <= bram_addr + 1'b1;
                            words_left_q <= words_left_q - 7'd1;
                            state_q <= st_fetch;
                        end
                    end
                end
                st_finish: begin
                    if (last_sample_taken) begin
                        phy_tx_done <= 1'b1;
                        bram_addr <= '0; // ready for the next header
                        state_q <= st_idle;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    // header written into BRAM by the host must be in range
    hdr_len_range: assert property (@(posedge clk) disable iff (!core_rst_n)
        state_q == st_read_hdr |-> hdr_len inside {[16'd1:16'd512]});

endmodule

// File: tx_core/tx_scrambler.sv
// 802.11 data scrambler, shifts payload words out LSB first
// and XORs each bit with the x^7 + x^4 + 1 sequence
`timescale 1ns/1ps
`include "ofdm_tx_consts.svh"

module tx_scrambler (
    input  logic       clk,
    input  logic       core_rst_n,
    input  logic [6:0] seed,
    input  logic       start,
    word_stream_if.dst words,
    bit_stream_if.src  bits
);
    logic [`OFDM_TX_WORD_W-1:0] shift_q;
    logic [6:0]                 left_q;  // bits still in shift_q
    logic                       last_word_q;
    logic [6:0]                 lfsr_q;
    logic                       fb;
    logic                       word_xfer;
    logic                       bit_xfer;

    assign fb = lfsr_q[6] ^ lfsr_q[3];
    assign word_xfer = words.valid & words.ready;
    assign bit_xfer = bits.valid & bits.ready;

    assign words.ready = (left_q == 7'd0); // only when empty
    assign bits.valid = (left_q != 7'd0);
    assign bits.data_bit = shift_q[0] ^ fb;
    assign bits.last = last_word_q & (left_q == 7'd1);

    always_ff @(posedge clk or negedge core_rst_n) begin
        if (!core_rst_n) begin
            left_q <= '0;
            last_word_q <= 1'b0;
            lfsr_q <= 7'h7F;
        end else begin
            if (start) lfsr_q <= seed;
            else if (bit_xfer) lfsr_q <= {lfsr_q[5:0], fb}; // one step per bit sent
            if (word_xfer) begin
                left_q <= words.nbits;
                last_word_q <= words.last;
            end else if (bit_xfer) begin
                left_q <= left_q - 7'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (word_xfer) shift_q <= words.data;
        else if (bit_xfer) shift_q <= shift_q >> 1;
    end

    // an all-zero state would lock the LFSR
    seed_nonzero: assert property (@(posedge clk) disable iff (!core_rst_n)
        start |-> seed != 7'd0);

endmodule

// File: tx_core/tx_bpsk_mapper.sv
// BPSK mapper with one registered output sample
// I from the data bit, Q from the pilot scrambler sign
`timescale 1ns/1ps

module tx_bpsk_mapper (
    input  logic               clk,
    input  logic               core_rst_n,
    input  logic [6:0]         pilot_seed,
    input  logic               start,
    bit_stream_if.dst          bits,
    input  logic               iq_hold,
    output logic               iq_valid,
    output logic signed [15:0] i_out,
    output logic signed [15:0] q_out,
    output logic               last_out
);
    localparam logic signed [15:0] AMP_POS = 16'sd8192;
    localparam logic signed [15:0] AMP_NEG = -16'sd8192;

    logic [6:0] pilot_q;
    logic       pilot_fb;
    logic       bit_xfer;

    assign pilot_fb = pilot_q[6] ^ pilot_q[3];
    assign bits.ready = ~iq_valid | ~iq_hold; // empty or draining this cycle
    assign bit_xfer = bits.valid & bits.ready;

    always_ff @(posedge clk or negedge core_rst_n) begin
        if (!core_rst_n) begin
            iq_valid <= 1'b0;
            pilot_q <= 7'h7F;
        end else begin
            if (start) pilot_q <= pilot_seed;
            else if (bit_xfer) pilot_q <= {pilot_q[5:0], pilot_fb}; // one step per sample
            if (bit_xfer) iq_valid <= 1'b1;
            else if (!iq_hold) iq_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (bit_xfer) begin
            i_out <= bits.data_bit ? AMP_NEG : AMP_POS;
            q_out <= pilot_fb ? AMP_NEG : AMP_POS;
            last_out <= bits.last;
        end
    end

    // a held sample must not move
    hold_stable: assert property (@(posedge clk) disable iff (!core_rst_n)
        iq_valid && iq_hold |=> iq_valid && $stable(i_out) && $stable(q_out));

endmodule

// File: src/tx_axil_regs.sv
// AXI4-Lite slave with control, seed and status registers
// one write and one read outstanding, unmapped offsets read as zero
`timescale 1ns/1ps
`include "ofdm_tx_consts.svh"

module tx_axil_regs import ofdm_tx_reg_pkg::*; (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [`OFDM_TX_AXI_AW-1:0]    s_axi_awaddr,
    input  logic [2:0]                    s_axi_awprot, // not checked, all accesses allowed
    input  logic                          s_axi_awvalid,
    output logic                          s_axi_awready,
    input  logic [`OFDM_TX_AXI_DW-1:0]    s_axi_wdata,
    input  logic [`OFDM_TX_AXI_DW/8-1:0]  s_axi_wstrb,
    input  logic                          s_axi_wvalid,
    output logic                          s_axi_wready,
    output logic [1:0]                    s_axi_bresp,
    output logic                          s_axi_bvalid,
    input  logic                          s_axi_bready,
    input  logic [`OFDM_TX_AXI_AW-1:0]    s_axi_araddr,
    input  logic [2:0]                    s_axi_arprot, // not checked either
    input  logic                          s_axi_arvalid,
    output logic                          s_axi_arready,
    output logic [`OFDM_TX_AXI_DW-1:0]    s_axi_rdata,
    output logic [1:0]                    s_axi_rresp,
    output logic                          s_axi_rvalid,
    input  logic                          s_axi_rready,
    output logic                          soft_reset,
    output logic [6:0]                    pilot_seed,
    output logic [6:0]                    data_seed,
    input  logic                          busy,
    input  logic                          frame_done
);
    ctrl_reg_t                  ctrl_q;
    logic [`OFDM_TX_AXI_DW-1:0] pilot_q;
    logic [`OFDM_TX_AXI_DW-1:0] data_q;
    logic [15:0]                frame_cnt_q;
    status_reg_t                status;
    logic                       wr_en;
    logic                       rd_en;
    logic [`OFDM_TX_AXI_AW-1:0] waddr;
    logic [`OFDM_TX_AXI_AW-1:0] raddr;
    logic [`OFDM_TX_AXI_DW-1:0] rd_word;

    // byte lanes with strobe low keep the old value
    function automatic logic [`OFDM_TX_AXI_DW-1:0] merge_strb(
        input logic [`OFDM_TX_AXI_DW-1:0]   old_val,
        input logic [`OFDM_TX_AXI_DW-1:0]   new_val,
        input logic [`OFDM_TX_AXI_DW/8-1:0] strb
    );
        logic [`OFDM_TX_AXI_DW-1:0] res;
        for (int i = 0; i < `OFDM_TX_AXI_DW / 8; i++) begin
            res[8*i +: 8] = strb[i] ? new_val[8*i +: 8] : old_val[8*i +: 8];
        end
        return res;
    endfunction

    assign waddr = {s_axi_awaddr[`OFDM_TX_AXI_AW-1:2], 2'b00}; // word aligned
    assign raddr = {s_axi_araddr[`OFDM_TX_AXI_AW-1:2], 2'b00};

    // address and data taken together, only when no response is pending
    assign wr_en = s_axi_awvalid & s_axi_wvalid & ~s_axi_bvalid;
    assign s_axi_awready = wr_en;
    assign s_axi_wready = wr_en;
    assign s_axi_bresp = 2'b00; // always OKAY
    assign s_axi_arready = ~s_axi_rvalid;
    assign rd_en = s_axi_arvalid & s_axi_arready;
    assign s_axi_rresp = 2'b00;

    assign soft_reset = ctrl_q.soft_reset;
    assign pilot_seed = pilot_q[6:0];
    assign data_seed = data_q[6:0];
    assign status = '{frame_count: frame_cnt_q, rsvd: '0, busy: busy};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_q <= '0;
            pilot_q <= 32'h0000_007F;
            data_q <= 32'h0000_005D;
            s_axi_bvalid <= 1'b0;
        end else begin
            if (wr_en) begin
                s_axi_bvalid <= 1'b1;
                case (waddr)
                    `OFDM_TX_REG_CTRL:       ctrl_q <= merge_strb(ctrl_q, s_axi_wdata, s_axi_wstrb);
                    `OFDM_TX_REG_PILOT_SEED: pilot_q <= merge_strb(pilot_q, s_axi_wdata, s_axi_wstrb);
                    `OFDM_TX_REG_DATA_SEED:  data_q <= merge_strb(data_q, s_axi_wdata, s_axi_wstrb);
                    default: ; // status and unmapped, write dropped
                endcase
            end else if (s_axi_bready) begin
                s_axi_bvalid <= 1'b0;
            end
        end
    end

    always_comb begin
        case (raddr)
            `OFDM_TX_REG_CTRL:       rd_word = ctrl_q;
            `OFDM_TX_REG_PILOT_SEED: rd_word = pilot_q;
            `OFDM_TX_REG_DATA_SEED:  rd_word = data_q;
            `OFDM_TX_REG_STATUS:     rd_word = status;
            default:                 rd_word = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s_axi_rvalid <= 1'b0;
            frame_cnt_q <= '0;
        end else begin
            if (rd_en) s_axi_rvalid <= 1'b1;
            else if (s_axi_rready) s_axi_rvalid <= 1'b0;
            if (frame_done) frame_cnt_q <= frame_cnt_q + 16'd1; // survives soft reset
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) s_axi_rdata <= rd_word;
    end

    // a write response only follows an address and data handshake
    bvalid_after_write: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(s_axi_bvalid) |->
            $past(s_axi_awvalid && s_axi_awready && s_axi_wvalid && s_axi_wready));

endmodule

// File: src/ofdm_tx_top.sv
// Top level of the single-stream OFDM transmit wrapper
// AXI4-Lite registers plus BRAM reader, scrambler and BPSK mapper
`timescale 1ns/1ps
`include "ofdm_tx_consts.svh"

module ofdm_tx_top (
    input  logic                          clk,
    input  logic                          arst_n,

    input  logic                          phy_tx_start,
    output logic                          phy_tx_done,
    output logic                          phy_tx_started,

    input  logic [`OFDM_TX_WORD_W-1:0]    bram_din,
    output logic [`OFDM_TX_BRAM_AW-1:0]   bram_addr,

    input  logic                          result_iq_hold,
    output logic                          result_iq_valid,
    output logic signed [15:0]            result_i,
    output logic signed [15:0]            result_q,

    input  logic [`OFDM_TX_AXI_AW-1:0]    s_axi_awaddr,
    input  logic [2:0]                    s_axi_awprot,
    input  logic                          s_axi_awvalid,
    output logic                          s_axi_awready,
    input  logic [`OFDM_TX_AXI_DW-1:0]    s_axi_wdata,
    input  logic [`OFDM_TX_AXI_DW/8-1:0]  s_axi_wstrb,
    input  logic                          s_axi_wvalid,
    output logic                          s_axi_wready,
    output logic [1:0]                    s_axi_bresp,
    output logic                          s_axi_bvalid,
    input  logic                          s_axi_bready,
    input  logic [`OFDM_TX_AXI_AW-1:0]    s_axi_araddr,
    input  logic [2:0]                    s_axi_arprot,
    input  logic                          s_axi_arvalid,
    output logic                          s_axi_arready,
    output logic [`OFDM_TX_AXI_DW-1:0]    s_axi_rdata,
    output logic [1:0]                    s_axi_rresp,
    output logic                          s_axi_rvalid,
    input  logic                          s_axi_rready
);
    logic       soft_reset;
    logic [6:0] pilot_seed;
    logic [6:0] data_seed;
    logic       busy;
    logic       frame_done;
    logic       core_rst_n;
    logic       sample_last;
    logic       last_sample_taken;

    word_stream_if words_if ();
    bit_stream_if  bits_if ();

    assign core_rst_n = arst_n & ~soft_reset; // soft reset clears only the core
    assign frame_done = phy_tx_done;
    assign last_sample_taken = result_iq_valid & ~result_iq_hold & sample_last;

    tx_axil_regs u_regs (.*); // register block stays on arst_n

    tx_ctrl u_ctrl (
        .clk               (clk),
        .core_rst_n        (core_rst_n),
        .phy_tx_start      (phy_tx_start),
        .phy_tx_started    (phy_tx_started),
        .phy_tx_done       (phy_tx_done),
        .busy              (busy),
        .bram_addr         (bram_addr),
        .bram_din          (bram_din),
        .words             (words_if.src),
        .last_sample_taken (last_sample_taken)
    );

    tx_scrambler u_scram (
        .clk        (clk),
        .core_rst_n (core_rst_n),
        .seed       (data_seed),
        .start      (phy_tx_started), // seeds load before the first word
        .words      (words_if.dst),
        .bits       (bits_if.src)
    );

    tx_bpsk_mapper u_map (
        .clk        (clk),
        .core_rst_n (core_rst_n),
        .pilot_seed (pilot_seed),
        .start      (phy_tx_started),
        .bits       (bits_if.dst),
        .iq_hold    (result_iq_hold),
        .iq_valid   (result_iq_valid),
        .i_out      (result_i),
        .q_out      (result_q),
        .last_out   (sample_last)
    );

endmodule

// File: sim/tb_ofdm_tx.sv
// Directed testbench for the OFDM transmit wrapper
// BRAM model, AXI4-Lite driver and reference scramblers around the DUT
`timescale 1ns/1ps
`include "ofdm_tx_consts.svh"

module tb_ofdm_tx;
    logic        clk;
    logic        arst_n;
    logic        phy_tx_start;
    logic        phy_tx_done;
    logic        phy_tx_started;
    logic [63:0] bram_din = '0;
    logic [9:0]  bram_addr;
    logic        result_iq_hold;
    logic        result_iq_valid;
    logic signed [15:0] result_i;
    logic signed [15:0] result_q;
    logic [6:0]  s_axi_awaddr;
    logic [2:0]  s_axi_awprot;
    logic        s_axi_awvalid;
    logic        s_axi_awready;
    logic [31:0] s_axi_wdata;
    logic [3:0]  s_axi_wstrb;
    logic        s_axi_wvalid;
    logic        s_axi_wready;
    logic [1:0]  s_axi_bresp;
    logic        s_axi_bvalid;
    logic        s_axi_bready;
    logic [6:0]  s_axi_araddr;
    logic [2:0]  s_axi_arprot;
    logic        s_axi_arvalid;
    logic        s_axi_arready;
    logic [31:0] s_axi_rdata;
    logic [1:0]  s_axi_rresp;
    logic        s_axi_rvalid;
    logic        s_axi_rready;

    logic [63:0] mem [0:1023]; // frame memory with the header in word 0
    integer      seed;
    logic [6:0]  pilot_seed_tb; // seeds last written to the DUT
    logic [6:0]  data_seed_tb;
    logic [15:0] frames_sent;
    int          started_cnt;
    int          done_cnt;

    ofdm_tx_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) bram_din <= mem[bram_addr]; // one cycle read latency

    // pulse counters read by the tests well after the edge
    always @(negedge clk) begin
        if (arst_n) begin
            if (phy_tx_started) started_cnt++;
            if (phy_tx_done) done_cnt++;
        end
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1; // inputs move 1 ns after the edge
    endtask

    task automatic axil_write(input logic [6:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        int guard;
        guard = 0;
        s_axi_awaddr = addr;
        s_axi_wdata = data;
        s_axi_wstrb = strb;
        s_axi_awvalid = 1'b1;
        s_axi_wvalid = 1'b1;
        @(negedge clk);
        while (!(s_axi_awready && s_axi_wready)) begin
            guard++;
            assert (guard < 50) else stop_run("timeout waiting for AXI write ready");
            @(negedge clk);
        end
        next_cycle();
        s_axi_awvalid = 1'b0;
        s_axi_wvalid = 1'b0;
        s_axi_bready = 1'b1;
        guard = 0;
        @(negedge clk);
        while (!s_axi_bvalid) begin
            guard++;
            assert (guard < 50) else stop_run("timeout waiting for AXI write response");
            @(negedge clk);
        end
        assert (s_axi_bresp == 2'b00)
            else stop_run($sformatf("ERROR s_axi_bresp got %h exp %h", s_axi_bresp, 2'b00));
        next_cycle();
        s_axi_bready = 1'b0;
    endtask

    task automatic axil_read(input logic [6:0] addr, output logic [31:0] data);
        int guard;
        guard = 0;
        s_axi_araddr = addr;
        s_axi_arvalid = 1'b1;
        @(negedge clk);
        while (!s_axi_arready) begin
            guard++;
            assert (guard < 50) else stop_run("timeout waiting for AXI read address ready");
            @(negedge clk);
        end
        next_cycle();
        s_axi_arvalid = 1'b0;
        s_axi_rready = 1'b1;
        guard = 0;
        @(negedge clk);
        while (!s_axi_rvalid) begin
            guard++;
            assert (guard < 50) else stop_run("timeout waiting for AXI read data");
            @(negedge clk);
        end
        data = s_axi_rdata;
        assert (s_axi_rresp == 2'b00)
            else stop_run($sformatf("ERROR s_axi_rresp got %h exp %h", s_axi_rresp, 2'b00));
        next_cycle();
        s_axi_rready = 1'b0;
    endtask

    task automatic check_reg(input logic [6:0] addr, input logic [31:0] exp, input string name);
        logic [31:0] got;
        axil_read(addr, got);
        assert (got == exp) else stop_run($sformatf("ERROR %s got %h exp %h", name, got, exp));
    endtask

    task automatic check_status();
        check_reg(`OFDM_TX_REG_STATUS, {frames_sent, 15'h0, 1'b0}, "status");
    endtask

    task automatic load_frame(input int len);
        mem[0] = {48'h0, 16'(len)};
        for (int w = 1; w <= (len + 7) / 8; w++) begin
            mem[w] = {$random(seed), $random(seed)}; // tail bytes past len are ignored
        end
    endtask

    task automatic pulse_start();
        phy_tx_start = 1'b1;
        next_cycle();
        phy_tx_start = 1'b0;
        assert (phy_tx_started == 1'b1)
            else stop_run($sformatf("ERROR phy_tx_started got %h exp %h", phy_tx_started, 1'b1));
    endtask

    // sends one frame and checks every accepted sample against both LFSRs
    task automatic run_frame(input int len, input bit random_hold, input bit restart);
        int          nbits;
        int          n;
        int          guard;
        int          st0;
        int          dn0;
        logic [6:0]  d;
        logic [6:0]  p;
        logic        fb;
        logic        pfb;
        logic        b;
        logic [31:0] r;
        logic signed [15:0] exp_i;
        logic signed [15:0] exp_q;
        load_frame(len);
        nbits = len * 8;
        n = 0;
        guard = 0;
        st0 = started_cnt;
        dn0 = done_cnt;
        d = data_seed_tb;
        p = pilot_seed_tb;
        pulse_start();
        while (n < nbits) begin
            r = $random(seed);
            result_iq_hold = random_hold && r[0];
            phy_tx_start = restart && (n == 8); // must be ignored while busy
            @(negedge clk);
            if (result_iq_valid && !result_iq_hold) begin
                b = mem[1 + n / 64][n % 64]; // LSB first within each word
                fb = d[6] ^ d[3];
                exp_i = (b ^ fb) ? -16'sd8192 : 16'sd8192;
                d = {d[5:0], fb};
                pfb = p[6] ^ p[3];
                exp_q = pfb ? -16'sd8192 : 16'sd8192;
                p = {p[5:0], pfb};
                assert (result_i == exp_i) else stop_run($sformatf(
                    "ERROR result_i sample %0d got %h exp %h", n, result_i, exp_i));
                assert (result_q == exp_q) else stop_run($sformatf(
                    "ERROR result_q sample %0d got %h exp %h", n, result_q, exp_q));
                n++;
                guard = 0;
            end else begin
                guard++;
                assert (guard < 100) else stop_run("timeout waiting for an output sample");
            end
            next_cycle();
        end
        result_iq_hold = 1'b0;
        phy_tx_start = 1'b0;
        @(negedge clk); // done follows the last accepted sample by one cycle
        assert (phy_tx_done == 1'b1) else stop_run($sformatf(
            "ERROR phy_tx_done after last sample got %h exp %h", phy_tx_done, 1'b1));
        repeat (3) next_cycle();
        frames_sent++;
        assert (started_cnt == st0 + 1) else stop_run($sformatf(
            "ERROR phy_tx_started pulses got %h exp %h", started_cnt - st0, 1));
        assert (done_cnt == dn0 + 1) else stop_run($sformatf(
            "ERROR phy_tx_done pulses got %h exp %h", done_cnt - dn0, 1));
        assert (result_iq_valid == 1'b0) else stop_run($sformatf(
            "ERROR result_iq_valid after frame got %h exp %h", result_iq_valid, 1'b0));
        check_status();
    endtask

    task automatic write_seeds(input logic [6:0] pilot, input logic [6:0] data);
        axil_write(`OFDM_TX_REG_PILOT_SEED, {25'h0, pilot}, 4'hF);
        axil_write(`OFDM_TX_REG_DATA_SEED, {25'h0, data}, 4'hF);
        pilot_seed_tb = pilot;
        data_seed_tb = data;
    endtask

    task automatic check_registers();
        check_reg(`OFDM_TX_REG_CTRL, 32'h0, "ctrl");
        check_reg(`OFDM_TX_REG_PILOT_SEED, 32'h7F, "pilot_seed");
        check_reg(`OFDM_TX_REG_DATA_SEED, 32'h5D, "data_seed");
        check_status();
        check_reg(7'h10, 32'h0, "unmapped");
        axil_write(`OFDM_TX_REG_PILOT_SEED, 32'h35, 4'hF);
        check_reg(`OFDM_TX_REG_PILOT_SEED, 32'h35, "pilot_seed");
        axil_write(`OFDM_TX_REG_DATA_SEED, 32'h1234_5671, 4'h1); // only byte 0 lands
        check_reg(`OFDM_TX_REG_DATA_SEED, 32'h71, "data_seed");
        axil_write(7'h20, 32'hDEAD_BEEF, 4'hF); // dropped
        check_reg(7'h20, 32'h0, "unmapped");
        pilot_seed_tb = 7'h35;
        data_seed_tb = 7'h71;
    endtask

    task automatic soft_reset_mid_frame();
        int guard;
        guard = 0;
        load_frame(40);
        pulse_start();
        @(negedge clk);
        while (!result_iq_valid) begin
            guard++;
            assert (guard < 50) else stop_run("timeout waiting for the first sample");
            @(negedge clk);
        end
        repeat (5) next_cycle();
        axil_write(`OFDM_TX_REG_CTRL, 32'h1, 4'hF);
        assert (result_iq_valid == 1'b0) else stop_run($sformatf(
            "ERROR result_iq_valid in soft reset got %h exp %h", result_iq_valid, 1'b0));
        assert (bram_addr == 10'h0) else stop_run($sformatf(
            "ERROR bram_addr in soft reset got %h exp %h", bram_addr, 10'h0));
        check_status(); // busy low and count unchanged
        axil_write(`OFDM_TX_REG_CTRL, 32'h0, 4'hF);
        write_seeds(7'h2B, 7'h4E);
        run_frame(13, 1'b1, 1'b0);
    endtask

    initial begin
        seed = 32'he60c_e5d1;
        for (int a = 0; a < 1024; a++) begin
            mem[a] = {22'h0, 10'(a), 22'h3F_FFFF, ~10'(a)};
        end
        arst_n = 1'b0;
        phy_tx_start = 1'b0;
        result_iq_hold = 1'b0;
        s_axi_awaddr = '0;
        s_axi_awprot = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata = '0;
        s_axi_wstrb = '0;
        s_axi_wvalid = 1'b0;
        s_axi_bready = 1'b0;
        s_axi_araddr = '0;
        s_axi_arprot = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready = 1'b0;
        frames_sent = '0;
        started_cnt = 0;
        done_cnt = 0;
        pilot_seed_tb = 7'h7F;
        data_seed_tb = 7'h5D;
        repeat (8) @(posedge clk);
        #1 arst_n = 1'b1;
        assert (!phy_tx_started && !phy_tx_done && !result_iq_valid && bram_addr == 10'h0)
            else stop_run("outputs not idle after reset");
        check_registers();
        run_frame(3, 1'b0, 1'b0);   // short frame with hold low
        run_frame(20, 1'b1, 1'b0);  // partial last word and random hold
        run_frame(70, 1'b0, 1'b1);  // second start while busy
        soft_reset_mid_frame();
        $display(">>> PASS");
        $finish;
    end

    // last line of defence against a stuck run
    initial begin
        #2_000_000;
        stop_run("simulation watchdog expired");
    end

endmodule

// File: files.f
+incdir+common
common/ofdm_tx_reg_pkg.sv
common/ofdm_tx_frame_pkg.sv
common/tx_stream_if.sv
tx_core/tx_ctrl.sv
tx_core/tx_scrambler.sv
tx_core/tx_bpsk_mapper.sv
src/tx_axil_regs.sv
src/ofdm_tx_top.sv
sim/tb_ofdm_tx.sv

// File: Makefile
# Verilator build and run of the OFDM transmit wrapper testbench
VERILATOR ?= verilator
TOP       ?= tb_ofdm_tx
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= >>> PASS

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(SIM) | tee /dev/stderr | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
